// ==== srio_type9_regs.f ====
hw/srio_regs_pkg.sv
hw/reg_wr_if.sv
hw/axil_wr_channel.sv
hw/axil_rd_channel.sv
hw/srio_reg_bank.sv
hw/srio_type9_regs.sv
bench/tb_reg_checker.sv
bench/tb_srio_type9_regs.sv

// ==== Makefile ====
# Verilator build and run for the SRIO type-9 register block

VERILATOR ?= verilator
TOP       ?= tb_srio_type9_regs
FILELIST  ?= srio_type9_regs.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard hw/*.sv bench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line appears in the output
test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_srio_type9_regs.sv ====
// Testbench for the SRIO type-9 register block
// Table-driven AXI-Lite master with random response back-pressure
`timescale 1ns/100ps

module tb_srio_type9_regs;

  localparam int timeout_cycles = 40;

  // One bus transaction, data is the expected word on reads
  typedef struct packed {
    logic [159:0] name;
    logic         is_write;
    logic [4:0]   addr;
    logic [31:0]  data;
    logic [3:0]   strb;
  } entry_t;

  logic         S_AXI_ACLK;
  logic         S_AXI_ARESETN;
  logic [4:0]   S_AXI_AWADDR;
  logic         S_AXI_AWVALID;
  logic         S_AXI_AWREADY;
  logic [31:0]  S_AXI_WDATA;
  logic [3:0]   S_AXI_WSTRB;
  logic         S_AXI_WVALID;
  logic         S_AXI_WREADY;
  logic [1:0]   S_AXI_BRESP;
  logic         S_AXI_BVALID;
  logic         S_AXI_BREADY;
  logic [4:0]   S_AXI_ARADDR;
  logic         S_AXI_ARVALID;
  logic         S_AXI_ARREADY;
  logic [31:0]  S_AXI_RDATA;
  logic [1:0]   S_AXI_RRESP;
  logic         S_AXI_RVALID;
  logic         S_AXI_RREADY;
  logic [31:0]  cmd;
  logic [31:0]  srio_stream_id;
  logic [159:0] test_name;
  logic [31:0]  test_exp;
  int           error_count;
  int           timeout_count;
  logic [7:0]   lfsr;
  entry_t       table_q [$];
  // Register contents expected after the partial writes
  logic [31:0]  final_vals [8];

  srio_type9_regs uut (.*);

  tb_reg_checker u_checker (
    .S_AXI_ACLK (S_AXI_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
    .aw_addr (S_AXI_AWADDR), .aw_valid (S_AXI_AWVALID), .aw_ready (S_AXI_AWREADY),
    .w_data (S_AXI_WDATA), .w_strb (S_AXI_WSTRB), .w_valid (S_AXI_WVALID),
    .w_ready (S_AXI_WREADY), .b_resp (S_AXI_BRESP), .b_valid (S_AXI_BVALID),
    .b_ready (S_AXI_BREADY), .ar_addr (S_AXI_ARADDR), .ar_valid (S_AXI_ARVALID),
    .ar_ready (S_AXI_ARREADY), .r_data (S_AXI_RDATA), .r_resp (S_AXI_RRESP),
    .r_valid (S_AXI_RVALID), .r_ready (S_AXI_RREADY), .cmd (cmd),
    .stream_id (srio_stream_id), .test_name (test_name), .test_exp (test_exp),
    .error_count (error_count)
  );

  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // 8-bit Fibonacci LFSR, taps 8 6 5 4, one step per bit
  function automatic int random_bits(input int n);
    int val;
    val = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic add_entry(input logic [159:0] name, input logic is_write,
                           input logic [4:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    entry_t e;
    e.name     = name;
    e.is_write = is_write;
    e.addr     = addr;
    e.data     = data;
    e.strb     = strb;
    table_q.push_back(e);
  endtask

  // Wait on the falling edge for a DUT output, bounded
  task automatic wait_high(ref logic sig, input string what, input logic [159:0] name);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge S_AXI_ACLK);
    while (!sig && (wait_cnt < timeout_cycles))
    begin
      @(negedge S_AXI_ACLK);
      wait_cnt++;
    end
    if (!sig)
    begin
      $display("%0s in test %0s", what, name);
      timeout_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Bus transactions
  //////////////////////////////////////////////////

  task automatic write_word(input entry_t e);
    int delay;
    @(posedge S_AXI_ACLK);
    test_name     <= e.name;
    test_exp      <= e.data;
    S_AXI_AWADDR  <= e.addr;
    S_AXI_WDATA   <= e.data;
    S_AXI_WSTRB   <= e.strb;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID  <= 1'b1;
    wait_high(S_AXI_AWREADY, "write address and data were never accepted", e.name);
    @(posedge S_AXI_ACLK);
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    // 0 to 3 cycles before the response is taken
    delay = random_bits(2);
    repeat (delay) @(posedge S_AXI_ACLK);
    S_AXI_BREADY <= 1'b1;
    wait_high(S_AXI_BVALID, "write response never arrived", e.name);
    @(posedge S_AXI_ACLK);
    S_AXI_BREADY <= 1'b0;
  endtask

  task automatic read_word(input entry_t e);
    int delay;
    @(posedge S_AXI_ACLK);
    test_name     <= e.name;
    test_exp      <= e.data;
    S_AXI_ARADDR  <= e.addr;
    S_AXI_ARVALID <= 1'b1;
    wait_high(S_AXI_ARREADY, "read address was never accepted", e.name);
    @(posedge S_AXI_ACLK);
    S_AXI_ARVALID <= 1'b0;
    delay = random_bits(2);
    repeat (delay) @(posedge S_AXI_ACLK);
    S_AXI_RREADY <= 1'b1;
    wait_high(S_AXI_RVALID, "read data never arrived", e.name);
    @(posedge S_AXI_ACLK);
    S_AXI_RREADY <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table and run
  //////////////////////////////////////////////////

  initial
  begin
    lfsr          = 8'd55;
    timeout_count = 0;
    S_AXI_ARESETN <= 1'b0;
    S_AXI_AWADDR  <= 5'd0;
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WDATA   <= 32'h0;
    S_AXI_WSTRB   <= 4'h0;
    S_AXI_WVALID  <= 1'b0;
    S_AXI_BREADY  <= 1'b0;
    S_AXI_ARADDR  <= 5'd0;
    S_AXI_ARVALID <= 1'b0;
    S_AXI_RREADY  <= 1'b0;
    test_name     <= "reset";
    test_exp      <= 32'h0;
    final_vals = '{32'h125AC03C, 32'hA15ABEEF, 32'hA2FFC2FF, 32'hA35AC33C,
                   32'hA45AC43C, 32'hA55AC53C, 32'hA65AC63C, 32'h0};

    // Every slot reads zero out of reset
    for (int i = 0; i < 8; i++)
    begin
      add_entry("reset_read", 1'b0, 5'(i * 4), 32'h0, 4'h0);
    end
    // Full-strobe writes, then read back
    for (int i = 0; i < 7; i++)
    begin
      add_entry("full_write", 1'b1, 5'(i * 4), 32'hA05AC03C + 32'(i) * 32'h01000100, 4'hF);
    end
    for (int i = 0; i < 8; i++)
    begin
      add_entry("full_read", 1'b0, 5'(i * 4),
                (i < 7) ? 32'hA05AC03C + 32'(i) * 32'h01000100 : 32'h0, 4'h0);
    end
    // Partial strobes touch only the enabled lanes
    add_entry("strb_0101", 1'b1, 5'h08, 32'hFFFFFFFF, 4'b0101);
    add_entry("strb_cmd_top", 1'b1, 5'h00, 32'h12345678, 4'b1000);
    add_entry("strb_sid_low", 1'b1, 5'h04, 32'h0000BEEF, 4'b0011);
    add_entry("strb_none", 1'b1, 5'h14, 32'hFFFFFFFF, 4'b0000);
    // Empty slot ignores the write
    add_entry("slot7_write", 1'b1, 5'h1C, 32'hDEADBEEF, 4'hF);
    for (int i = 0; i < 8; i++)
    begin
      add_entry("final_read", 1'b0, 5'(i * 4), final_vals[i], 4'h0);
    end

    repeat (5) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    // Idle cycles for the quiet-bus check
    repeat (3) @(posedge S_AXI_ACLK);

    foreach (table_q[i])
    begin
      if (table_q[i].is_write)
      begin
        write_word(table_q[i]);
      end
      else
      begin
        read_word(table_q[i]);
      end
    end

    repeat (4) @(posedge S_AXI_ACLK);
    $display("errors: %0d  timeouts: %0d", error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0))
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/tb_reg_checker.sv ====
// Register block checker
// Watches the AXI-Lite ports, models the seven registers and compares responses
`timescale 1ns/100ps

module tb_reg_checker
(
  input  logic         S_AXI_ACLK,
  input  logic         S_AXI_ARESETN,
  // Write side
  input  logic [4:0]   aw_addr,
  input  logic         aw_valid,
  input  logic         aw_ready,
  input  logic [31:0]  w_data,
  input  logic [3:0]   w_strb,
  input  logic         w_valid,
  input  logic         w_ready,
  input  logic [1:0]   b_resp,
  input  logic         b_valid,
  input  logic         b_ready,
  // Read side
  input  logic [4:0]   ar_addr,
  input  logic         ar_valid,
  input  logic         ar_ready,
  input  logic [31:0]  r_data,
  input  logic [1:0]   r_resp,
  input  logic         r_valid,
  input  logic         r_ready,
  // Unpack path controls
  input  logic [31:0]  cmd,
  input  logic [31:0]  stream_id,
  // Current table entry
  input  logic [159:0] test_name,
  input  logic [31:0]  test_exp,
  output int           error_count
);

  // Reference copy of the seven registers
  logic [31:0] model [7];
  logic [2:0]  rd_idx_q;
  logic        started;
  logic        b_valid_q;
  // Response pending under back-pressure
  logic        b_hold;
  logic        r_hold;
  logic [31:0] r_hold_data;
  int          errors = 0;

  assign error_count = errors;

  // Slot 7 is empty and reads as zero
  function automatic logic [31:0] model_word(input logic [2:0] idx);
    if (idx < 3'd7)
    begin
      return model[idx];
    end
    return 32'h0;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("MISMATCH %0s %0s expected %08h actual %08h", test_name, what, exp_val, act_val);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%0s in test %0s", msg, test_name);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Port sampling on the falling edge
  //////////////////////////////////////////////////

  always @(negedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < 7; i++)
      begin
        model[i] = 32'h0;
      end
      rd_idx_q    = 3'd0;
      started     = 1'b0;
      b_valid_q   = 1'b0;
      b_hold      = 1'b0;
      r_hold      = 1'b0;
      r_hold_data = 32'h0;
    end
    else
    begin
      // Quiet bus and cleared outputs until the first request
      if (!started)
      begin
        if (aw_ready || w_ready || b_valid || ar_ready || r_valid)
        begin
          report_failure("ready or valid output high before the first request");
        end
        if (cmd != 32'h0)
        begin
          report_mismatch("idle cmd", 32'h0, cmd);
        end
        if (stream_id != 32'h0)
        begin
          report_mismatch("idle stream id", 32'h0, stream_id);
        end
        started = aw_valid || ar_valid;
      end

      // Address and data ready pulse together
      if (aw_ready != w_ready)
      begin
        report_failure("AWREADY and WREADY out of step");
      end

      // Responses must hold until accepted
      if (b_hold && !b_valid)
      begin
        report_failure("BVALID dropped before BREADY");
      end
      if (r_hold && !r_valid)
      begin
        report_failure("RVALID dropped before RREADY");
      end
      else if (r_hold && (r_data != r_hold_data))
      begin
        report_mismatch("held rdata", r_hold_data, r_data);
      end

      // Write handshake, strobed bytes only, slot 7 dropped
      if (aw_ready && aw_valid && w_valid && (aw_addr[4:2] < 3'd7))
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (w_strb[b])
          begin
            model[aw_addr[4:2]][b*8 +: 8] = w_data[b*8 +: 8];
          end
        end
      end

      if (ar_ready && ar_valid)
      begin
        rd_idx_q = ar_addr[4:2];
      end

      // Outputs already follow the registers when BVALID rises
      if (b_valid && !b_valid_q)
      begin
        if (cmd != model[0])
        begin
          report_mismatch("cmd", model[0], cmd);
        end
        if (stream_id != model[1])
        begin
          report_mismatch("stream id", model[1], stream_id);
        end
      end

      if (b_valid && b_ready && (b_resp != 2'b00))
      begin
        report_mismatch("bresp", 32'h0, 32'(b_resp));
      end

      // Read data against the model and the table
      if (r_valid && r_ready)
      begin
        if (r_data != model_word(rd_idx_q))
        begin
          report_mismatch("rdata", model_word(rd_idx_q), r_data);
        end
        if (r_data != test_exp)
        begin
          report_mismatch("rdata vs table", test_exp, r_data);
        end
        if (r_resp != 2'b00)
        begin
          report_mismatch("rresp", 32'h0, 32'(r_resp));
        end
      end

      b_valid_q   = b_valid;
      b_hold      = b_valid && !b_ready;
      r_hold      = r_valid && !r_ready;
      r_hold_data = r_data;
    end
  end

endmodule

// ==== hw/srio_type9_regs.sv ====
// SRIO type-9 unpack register block
// AXI-Lite slave with seven control registers, drives command and stream ID
`timescale 1ns/100ps

module srio_type9_regs
#(
  parameter int DATA_W = srio_regs_pkg::axi_data_w,
  parameter int ADDR_W = srio_regs_pkg::axi_addr_w
)
(
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  // Write address channel
  input  logic [ADDR_W-1:0]                     S_AXI_AWADDR,
  input  logic                                  S_AXI_AWVALID,
  output logic                                  S_AXI_AWREADY,
  // Write data channel
  input  logic [DATA_W-1:0]                     S_AXI_WDATA,
  input  logic [srio_regs_pkg::axi_strb_w-1:0]  S_AXI_WSTRB,
  input  logic                                  S_AXI_WVALID,
  output logic                                  S_AXI_WREADY,
  // Write response channel
  output srio_regs_pkg::axi_resp_t              S_AXI_BRESP,
  output logic                                  S_AXI_BVALID,
  input  logic                                  S_AXI_BREADY,
  // Read address channel
  input  logic [ADDR_W-1:0]                     S_AXI_ARADDR,
  input  logic                                  S_AXI_ARVALID,
  output logic                                  S_AXI_ARREADY,
  // Read data channel
  output logic [DATA_W-1:0]                     S_AXI_RDATA,
  output srio_regs_pkg::axi_resp_t              S_AXI_RRESP,
  output logic                                  S_AXI_RVALID,
  input  logic                                  S_AXI_RREADY,
  // Unpack path controls
  output logic [DATA_W-1:0]                     cmd,
  output logic [DATA_W-1:0]                     srio_stream_id
);

  import srio_regs_pkg::*;

  // Read lookup between channel and bank
  reg_idx_t          rd_idx;
  logic [DATA_W-1:0] rd_data;

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////

  reg_wr_if #(.DATA_W(DATA_W)) wr_bus ();

  axil_wr_channel #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_wr_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .wr            (wr_bus.master)
  );

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  axil_rd_channel #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_rd_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  // Register state shared by both channels
  srio_reg_bank #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_reg_bank (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .S_AXI_ARESETN  (S_AXI_ARESETN),
    .wr             (wr_bus.bank),
    .rd_idx         (rd_idx),
    .rd_data        (rd_data),
    .cmd            (cmd),
    .srio_stream_id (srio_stream_id)
  );

endmodule

// ==== hw/srio_reg_bank.sv ====
// SRIO type-9 control register bank
// Seven strobe-written words, read lookup, command and stream-ID outputs
`timescale 1ns/100ps

module srio_reg_bank
#(
  parameter int DATA_W = srio_regs_pkg::axi_data_w,
  parameter int ADDR_W = srio_regs_pkg::axi_addr_w
)
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // Write request from the write channel
  reg_wr_if.bank                   wr,
  // Read lookup from the read channel
  input  srio_regs_pkg::reg_idx_t  rd_idx,
  output logic [DATA_W-1:0]        rd_data,
  // Unpack path controls
  output logic [DATA_W-1:0]        cmd,
  output logic [DATA_W-1:0]        srio_stream_id
);

  import srio_regs_pkg::*;

  // Every word slot the address space can reach
  localparam int word_slots = 1 << (ADDR_W - addr_lsb);

  logic [DATA_W-1:0] regs     [reg_count];
  // Read view, empty slots tied to zero
  logic [DATA_W-1:0] rd_words [word_slots];

  //////////////////////////////////////////////////
  // Strobed register writes
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < reg_count; i++)
      begin
        regs[i] <= '0;
      end
    end
    // Writes to the empty slot are dropped
    else if (wr.wr_en && (wr.wr_idx < reg_count))
    begin
      for (int b = 0; b < axi_strb_w; b++)
      begin
        // Only enabled lanes change
        if (wr.wr_strb[b])
        begin
          regs[wr.wr_idx][b*8 +: 8] <= wr.wr_data[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read lookup
  //////////////////////////////////////////////////

  for (genvar g = 0; g < word_slots; g++)
  begin : g_slot
    if (g < reg_count)
    begin : g_reg
      assign rd_words[g] = regs[g];
    end
    else
    begin : g_empty
      // Unimplemented, reads as zero
      assign rd_words[g] = '0;
    end
  end

  assign rd_data = rd_words[rd_idx];

  // Outputs follow the registers with no extra stage
  assign cmd            = regs[idx_cmd];
  assign srio_stream_id = regs[idx_stream_id];

endmodule

// ==== hw/axil_rd_channel.sv ====
// AXI-Lite read channel
// Accepts a read address, fetches the word from the bank and holds it until taken
`timescale 1ns/100ps

module axil_rd_channel
#(
  parameter int DATA_W = srio_regs_pkg::axi_data_w,
  parameter int ADDR_W = srio_regs_pkg::axi_addr_w
)
(
  input  logic                       S_AXI_ACLK,
  input  logic                       S_AXI_ARESETN,
  // Read address
  input  logic [ADDR_W-1:0]          S_AXI_ARADDR,
  input  logic                       S_AXI_ARVALID,
  output logic                       S_AXI_ARREADY,
  // Read data
  output logic [DATA_W-1:0]          S_AXI_RDATA,
  output srio_regs_pkg::axi_resp_t   S_AXI_RRESP,
  output logic                       S_AXI_RVALID,
  input  logic                       S_AXI_RREADY,
  // Lookup into the register bank
  output srio_regs_pkg::reg_idx_t    rd_idx,
  input  logic [DATA_W-1:0]          rd_data
);

  import srio_regs_pkg::*;

  logic              ar_ready;
  // Latched read byte address
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid;
  logic [DATA_W-1:0] r_data;
  // Address accepted while no data is pending
  logic              rd_fire;

  //////////////////////////////////////////////////
  // Address acceptance
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ar_ready <= 1'b0;
    end
    else
    begin
      // Single-cycle ready pulse per request
      ar_ready <= !ar_ready && S_AXI_ARVALID;
    end
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!ar_ready && S_AXI_ARVALID)
    begin
      ar_addr <= S_AXI_ARADDR;
    end
  end

  assign S_AXI_ARREADY = ar_ready;
  assign rd_idx        = ar_addr[addr_lsb +: $bits(reg_idx_t)];
  assign rd_fire       = ar_ready && S_AXI_ARVALID && !r_valid;

  //////////////////////////////////////////////////
  // Read data and response
  //////////////////////////////////////////////////

  // Word captured at the handshake, held steady under back-pressure
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      r_valid <= 1'b0;
      r_data  <= '0;
    end
    else if (rd_fire)
    begin
      r_valid <= 1'b1;
      r_data  <= rd_data;
    end
    else if (r_valid && S_AXI_RREADY)
    begin
      r_valid <= 1'b0;
    end
  end

  assign S_AXI_RVALID = r_valid;
  assign S_AXI_RRESP  = resp_okay;
  assign S_AXI_RDATA  = r_data;

endmodule

// ==== hw/axil_wr_channel.sv ====
// AXI-Lite write channel
// Accepts address and data together, issues a register write and an OKAY response
`timescale 1ns/100ps

module axil_wr_channel
#(
  parameter int DATA_W = srio_regs_pkg::axi_data_w,
  parameter int ADDR_W = srio_regs_pkg::axi_addr_w
)
(
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  // Write address
  input  logic [ADDR_W-1:0]                     S_AXI_AWADDR,
  input  logic                                  S_AXI_AWVALID,
  output logic                                  S_AXI_AWREADY,
  // Write data
  input  logic [DATA_W-1:0]                     S_AXI_WDATA,
  input  logic [srio_regs_pkg::axi_strb_w-1:0]  S_AXI_WSTRB,
  input  logic                                  S_AXI_WVALID,
  output logic                                  S_AXI_WREADY,
  // Write response
  output srio_regs_pkg::axi_resp_t              S_AXI_BRESP,
  output logic                                  S_AXI_BVALID,
  input  logic                                  S_AXI_BREADY,
  // Request toward the register bank
  reg_wr_if.master                              wr
);

  import srio_regs_pkg::*;

  // Shared ready for address and data channels
  logic              wr_ready;
  // Latched write byte address
  logic [ADDR_W-1:0] aw_addr;
  logic              b_valid;
  // Both channels complete in this cycle
  logic              wr_fire;

  //////////////////////////////////////////////////
  // Address and data acceptance
  //////////////////////////////////////////////////

  // Wait for both valids, then pulse ready for a single cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      wr_ready <= 1'b0;
    end
    else if (!wr_ready && S_AXI_AWVALID && S_AXI_WVALID)
    begin
      wr_ready <= 1'b1;
    end
    else
    begin
      wr_ready <= 1'b0;
    end
  end

  // Address held for the handshake cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!wr_ready && S_AXI_AWVALID && S_AXI_WVALID)
    begin
      aw_addr <= S_AXI_AWADDR;
    end
  end

  assign S_AXI_AWREADY = wr_ready;
  assign S_AXI_WREADY  = wr_ready;

  // Master keeps data and strobes stable until ready
  assign wr_fire = wr_ready && S_AXI_AWVALID && S_AXI_WVALID;

  //////////////////////////////////////////////////
  // Register write request
  //////////////////////////////////////////////////

  assign wr.wr_en   = wr_fire;
  assign wr.wr_idx  = aw_addr[addr_lsb +: $bits(reg_idx_t)];
  assign wr.wr_data = S_AXI_WDATA;
  assign wr.wr_strb = S_AXI_WSTRB;

  //////////////////////////////////////////////////
  // Write response
  //////////////////////////////////////////////////

  // Raised on the edge that ends the handshake, held until BREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      b_valid <= 1'b0;
    end
    else if (wr_fire && !b_valid)
    begin
      b_valid <= 1'b1;
    end
    else if (b_valid && S_AXI_BREADY)
    begin
      b_valid <= 1'b0;
    end
  end

  assign S_AXI_BVALID = b_valid;
  assign S_AXI_BRESP  = resp_okay;

endmodule

// ==== hw/reg_wr_if.sv ====
// Register write request
// One strobed word write from the AXI write channel into the register bank
`timescale 1ns/100ps

interface reg_wr_if
#(
  parameter int DATA_W = srio_regs_pkg::axi_data_w
);

  import srio_regs_pkg::*;

  // One-cycle write pulse
  logic                  wr_en;
  // Target word slot
  reg_idx_t              wr_idx;
  logic [DATA_W-1:0]     wr_data;
  // Byte enables, one per lane
  logic [axi_strb_w-1:0] wr_strb;

  // Write channel side
  modport master (
    output wr_en,
    output wr_idx,
    output wr_data,
    output wr_strb
  );

  // Register bank side
  modport bank (
    input wr_en,
    input wr_idx,
    input wr_data,
    input wr_strb
  );

endinterface

// ==== hw/srio_regs_pkg.sv ====
// SRIO type-9 unpack register block
// Shared bus widths, register map indexes and response codes
package srio_regs_pkg;

  //////////////////////////////////////////////////
  // AXI-Lite bus geometry
  //////////////////////////////////////////////////

  // One 32-bit word per register
  localparam int axi_data_w = 32;

  // Byte address, eight word slots
  localparam int axi_addr_w = 5;

  // One strobe per byte lane
  localparam int axi_strb_w = axi_data_w / 8;

  // Byte offset bits below the word index
  localparam int addr_lsb = 2;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  // Slot 7 is left empty
  localparam int reg_count = 7;

  // Word index, address bits 4 to 2
  typedef logic [2:0] reg_idx_t;

  localparam reg_idx_t idx_cmd       = 3'd0;
  localparam reg_idx_t idx_stream_id = 3'd1;

  //////////////////////////////////////////////////
  // Response codes
  //////////////////////////////////////////////////

  typedef logic [1:0] axi_resp_t;

  // Only OKAY is ever returned
  localparam axi_resp_t resp_okay = 2'b00;

endpackage
